// ==== tile_dot.f ====
design/dram_pkg.sv
design/array_pkg.sv
design/beat_sink.sv
design/feature_row_packer.sv
design/weight_row_packer.sv
design/dot_accumulator.sv
design/tile_dot_top.sv
dv/tile_dot_tb.sv

// ==== Bender.yml ====
package:
  name: tile_dot

sources:
  - design/dram_pkg.sv
  - design/array_pkg.sv
  - design/beat_sink.sv
  - design/feature_row_packer.sv
  - design/weight_row_packer.sv
  - design/dot_accumulator.sv
  - design/tile_dot_top.sv
  - target: simulation
    files:
      - dv/tile_dot_tb.sv

// ==== dv/tile_dot_patterns.hex ====
// word 0 is the tile count, then per tile: header, row_count*4 feature beats,
// row_count*4 weight beats, expected result; header bits 7:0 rows, 11:8 shift
00000006
// one row, shift 0
00000001
04030201 08070605 0c0b0a09 100f0e0d
02020202 02020202 02020202 02020202
00000110
// two rows, shift 5, mixed signs, rounds toward minus infinity
00000502
ff02fe01 ff02fe01 ff02fe01 ff02fe01 10101010 10101010 10101010 10101010
03fd0405 03fd0405 03fd0405 03fd0405 f0080402 f0080402 f0080402 f0080402
0000fffa
// three rows, shift 3
00000303
7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 80808080 80808080 80808080 80808080
01020304 01020304 01020304 01020304
01010101 01010101 01010101 01010101 ff00ff00 ff00ff00 ff00ff00 ff00ff00
06fbff09 06fbff09 06fbff09 06fbff09
0000018c
// positive overflow, then negative overflow with shift 2
00000001 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
00007fff
00000201 80808080 80808080 80808080 80808080 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
00008000
// reserved header bits set, shift 4 brings the sum back in range
abcde401 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
00003f01

// ==== dv/tile_dot_tb.sv ====
`timescale 1ns/1ps

module tile_dot_tb;

    localparam int ROW_BEATS      = 4;
    localparam int MEM_WORDS      = 256;
    localparam int BEAT_TIMEOUT   = 1000;
    localparam int RESULT_TIMEOUT = 4000;
    localparam int IDLE_CYCLES    = 8;

    logic                            clk_i;
    logic                            rd_weight_rst;
    logic                            feat_req_i;
    logic [dram_pkg::BEAT_WIDTH-1:0] feat_data_i;
    logic                            feat_ack_o;
    logic                            wgt_req_i;
    logic [dram_pkg::BEAT_WIDTH-1:0] wgt_data_i;
    logic                            wgt_ack_o;
    logic                            res_req_o;
    array_pkg::result_t              res_data_o;
    logic                            res_ack_i;

    logic [31:0]        pattern_mem [MEM_WORDS];
    logic [31:0]        feat_beats [$];
    logic [31:0]        wgt_beats [$];
    logic [31:0]        tile_hdr [$];
    array_pkg::result_t expected [$];
    bit [31:0]          lcg_state = 32'h98c9781a;
    int                 errors = 0;
    int                 checks = 0;
    int                 proto_errors = 0;
    int                 res_rises = 0;
    bit                 abort = 1'b0;
    logic               feat_ack_prev = 1'b0;
    logic               wgt_ack_prev = 1'b0;
    logic               res_req_prev = 1'b0;
    array_pkg::result_t res_data_prev = '0;

    tile_dot_top #(
        .ROW_BEATS(ROW_BEATS)
    ) tile_dot_top_inst (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .feat_req_i   (feat_req_i),
        .feat_data_i  (feat_data_i),
        .feat_ack_o   (feat_ack_o),
        .wgt_req_i    (wgt_req_i),
        .wgt_data_i   (wgt_data_i),
        .wgt_ack_o    (wgt_ack_o),
        .res_req_o    (res_req_o),
        .res_data_o   (res_data_o),
        .res_ack_i    (res_ack_i)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        return int'((next_random() >> 8) % n);
    endfunction

    function automatic logic ack_level(input bit to_wgt);
        return to_wgt ? wgt_ack_o : feat_ack_o;
    endfunction

    // split the pattern words into the two beat streams and the results
    task automatic load_patterns();
        int ptr;
        int beats;
        int tiles;
        $readmemh("dv/tile_dot_patterns.hex", pattern_mem);
        tiles = int'(pattern_mem[0]);
        ptr = 1;
        if ($isunknown(pattern_mem[0])) begin
            $display("pattern file could not be read");
            errors++;
            tiles = 0;
        end
        for (int t = 0; t < tiles; t++) begin
            beats = int'(pattern_mem[ptr][7:0]) * ROW_BEATS;
            tile_hdr.push_back(pattern_mem[ptr]);
            feat_beats.push_back(pattern_mem[ptr]);
            ptr++;
            for (int i = 0; i < beats; i++) begin
                feat_beats.push_back(pattern_mem[ptr + i]);
            end
            ptr += beats;
            for (int i = 0; i < beats; i++) begin
                wgt_beats.push_back(pattern_mem[ptr + i]);
            end
            ptr += beats;
            expected.push_back(pattern_mem[ptr][15:0]);
            ptr++;
        end
    endtask

    task automatic check_low(input string name, input logic value);
        checks++;
        assert (value === 1'b0) else begin
            $display("FAILED %s: expected 0x0, got 0x%0h", name, value);
            errors++;
        end
    endtask

    task automatic check_idle();
        int errors_before;
        errors_before = errors;
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(negedge clk_i);
            check_low("feat_ack_o", feat_ack_o);
            check_low("wgt_ack_o", wgt_ack_o);
            check_low("res_req_o", res_req_o);
        end
        $display("test reset idle: %s", (errors == errors_before) ? "passed" : "failed");
    endtask

    //////////////////////////////////////////////////
    // four-phase source and result sink
    //////////////////////////////////////////////////

    task automatic send_beat(input bit to_wgt, input logic [31:0] data);
        int    waited;
        string name;
        name = to_wgt ? "weight" : "feature";
        if (abort) begin
            return;
        end
        repeat (random_below(4)) @(posedge clk_i);
        @(posedge clk_i);
        if (to_wgt) begin
            wgt_data_i <= data;
            wgt_req_i  <= 1'b1;
        end else begin
            feat_data_i <= data;
            feat_req_i  <= 1'b1;
        end
        waited = 0;
        @(negedge clk_i);
        while (ack_level(to_wgt) !== 1'b1 && waited < BEAT_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (ack_level(to_wgt) !== 1'b1) begin
            $display("timeout: %s beat 0x%08h was never acknowledged", name, data);
            errors++;
            abort = 1'b1;
            return;
        end
        @(posedge clk_i);
        if (to_wgt) begin
            wgt_req_i <= 1'b0;
        end else begin
            feat_req_i <= 1'b0;
        end
        waited = 0;
        @(negedge clk_i);
        while (ack_level(to_wgt) !== 1'b0 && waited < BEAT_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (ack_level(to_wgt) !== 1'b0) begin
            $display("timeout: %s ack stayed high after req was dropped", name);
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic collect_result(input int idx);
        int waited;
        int errors_before;
        errors_before = errors;
        waited = 0;
        @(negedge clk_i);
        while (res_req_o !== 1'b1 && waited < RESULT_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (res_req_o !== 1'b1) begin
            $display("timeout: no result offered for tile %0d", idx);
            errors++;
            abort = 1'b1;
            return;
        end
        checks++;
        assert (res_data_o === expected[idx]) else begin
            $display("FAILED tile %0d res_data_o: expected 0x%04h, got 0x%04h",
                     idx, expected[idx], res_data_o);
            errors++;
        end
        // later tiles hold the result back so both sources stall behind it
        if (idx >= 2) begin
            repeat (20 + random_below(60)) @(posedge clk_i);
        end else begin
            repeat (random_below(3)) @(posedge clk_i);
        end
        @(posedge clk_i);
        res_ack_i <= 1'b1;
        waited = 0;
        @(negedge clk_i);
        while (res_req_o !== 1'b0 && waited < RESULT_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (res_req_o !== 1'b0) begin
            $display("timeout: res_req_o stayed high after ack for tile %0d", idx);
            errors++;
            abort = 1'b1;
        end
        // ack lingers a few cycles after req falls, the next offer must wait
        repeat (random_below(8)) @(posedge clk_i);
        @(posedge clk_i);
        res_ack_i <= 1'b0;
        $display("test tile %0d (rows %0d, shift %0d): result 0x%04h, %s", idx,
                 tile_hdr[idx][7:0], tile_hdr[idx][11:8], res_data_o,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    // protocol watch over the whole run
    always @(negedge clk_i) begin
        if (!rd_weight_rst) begin
            if (feat_ack_o && !feat_ack_prev) begin
                assert (feat_req_i) else begin
                    $display("feature ack rose while feature req was low");
                    errors++;
                    proto_errors++;
                end
            end
            if (wgt_ack_o && !wgt_ack_prev) begin
                assert (wgt_req_i) else begin
                    $display("weight ack rose while weight req was low");
                    errors++;
                    proto_errors++;
                end
            end
            if (res_req_o && !res_req_prev) begin
                res_rises++;
                assert (!res_ack_i) else begin
                    $display("res_req_o rose while res_ack_i was still high");
                    errors++;
                    proto_errors++;
                end
            end
            if (res_req_o && res_req_prev) begin
                assert (res_data_o === res_data_prev) else begin
                    $display("FAILED res_data_o changed under res_req_o: was 0x%04h, now 0x%04h",
                             res_data_prev, res_data_o);
                    errors++;
                    proto_errors++;
                end
            end
        end
        feat_ack_prev = feat_ack_o;
        wgt_ack_prev  = wgt_ack_o;
        res_req_prev  = res_req_o;
        res_data_prev = res_data_o;
    end

    initial begin
        rd_weight_rst = 1'b1;
        feat_req_i    = 1'b0;
        feat_data_i   = '0;
        wgt_req_i     = 1'b0;
        wgt_data_i    = '0;
        res_ack_i     = 1'b0;
        load_patterns();
        repeat (4) @(posedge clk_i);
        rd_weight_rst <= 1'b0;
        check_idle();
        fork
            begin
                foreach (feat_beats[i]) begin
                    send_beat(1'b0, feat_beats[i]);
                end
            end
            begin
                foreach (wgt_beats[i]) begin
                    send_beat(1'b1, wgt_beats[i]);
                end
            end
            begin
                for (int t = 0; t < expected.size(); t++) begin
                    if (!abort) begin
                        collect_result(t);
                    end
                end
            end
        join
        // no stray result after the last tile
        repeat (20) @(negedge clk_i);
        checks++;
        assert (res_rises == expected.size()) else begin
            $display("FAILED result count: expected 0x%0h, got 0x%0h",
                     expected.size(), res_rises);
            errors++;
        end
        $display("test protocol: %0d violations", proto_errors);
        $display("summary: %0d tiles, %0d checks, %0d errors", expected.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== design/tile_dot_top.sv ====
`timescale 1ns/1ps

module tile_dot_top #(
    parameter  int ROW_BEATS = 4,
    localparam int ROW_LANES = ROW_BEATS * dram_pkg::LANES_PER_BEAT
) (
    input  logic                           clk_i,
    input  logic                           rd_weight_rst,
    input  logic                           feat_req_i,
    input  logic [dram_pkg::BEAT_WIDTH-1:0] feat_data_i,
    output logic                           feat_ack_o,
    input  logic                           wgt_req_i,
    input  logic [dram_pkg::BEAT_WIDTH-1:0] wgt_data_i,
    output logic                           wgt_ack_o,
    output logic                           res_req_o,
    output array_pkg::result_t             res_data_o,
    input  logic                           res_ack_i
);

    array_pkg::lane_t                     feat_row [ROW_LANES];
    array_pkg::lane_t                     wgt_row [ROW_LANES];
    logic                                 feat_row_valid;
    logic                                 wgt_row_valid;
    logic                                 row_take;
    logic [dram_pkg::ROW_COUNT_WIDTH-1:0] row_count;
    logic [dram_pkg::SHIFT_WIDTH-1:0]     frac_shift;

    //////////////////////////////////////////////////
    // load path
    //////////////////////////////////////////////////

    feature_row_packer #(
        .ROW_BEATS(ROW_BEATS)
    ) feat_packer_inst (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .req_i        (feat_req_i),
        .data_i       (feat_data_i),
        .ack_o        (feat_ack_o),
        .row_take_i   (row_take),
        .row_o        (feat_row),
        .row_valid_o  (feat_row_valid),
        .row_count_o  (row_count),
        .frac_shift_o (frac_shift)
    );

    weight_row_packer #(
        .ROW_BEATS(ROW_BEATS)
    ) wgt_packer_inst (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .req_i        (wgt_req_i),
        .data_i       (wgt_data_i),
        .ack_o        (wgt_ack_o),
        .row_take_i   (row_take),
        .row_o        (wgt_row),
        .row_valid_o  (wgt_row_valid)
    );

    // compute core, one take pulse feeds both packers
    dot_accumulator #(
        .ROW_BEATS(ROW_BEATS)
    ) dot_acc_inst (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .feat_row_i   (feat_row),
        .wgt_row_i    (wgt_row),
        .feat_valid_i (feat_row_valid),
        .wgt_valid_i  (wgt_row_valid),
        .row_count_i  (row_count),
        .frac_shift_i (frac_shift),
        .row_take_o   (row_take),
        .res_req_o    (res_req_o),
        .res_data_o   (res_data_o),
        .res_ack_i    (res_ack_i)
    );

endmodule

// ==== design/dot_accumulator.sv ====
`timescale 1ns/1ps

module dot_accumulator #(
    parameter  int ROW_BEATS = 4,
    localparam int ROW_LANES = ROW_BEATS * dram_pkg::LANES_PER_BEAT
) (
    input  logic                                 clk_i,
    input  logic                                 rd_weight_rst,
    input  array_pkg::lane_t                     feat_row_i [ROW_LANES],
    input  array_pkg::lane_t                     wgt_row_i [ROW_LANES],
    input  logic                                 feat_valid_i,
    input  logic                                 wgt_valid_i,
    input  logic [dram_pkg::ROW_COUNT_WIDTH-1:0] row_count_i,
    input  logic [dram_pkg::SHIFT_WIDTH-1:0]     frac_shift_i,
    output logic                                 row_take_o,
    output logic                                 res_req_o,
    output array_pkg::result_t                   res_data_o,
    input  logic                                 res_ack_i
);

    // result handshake states
    localparam logic [1:0] RES_IDLE  = 2'd0;
    localparam logic [1:0] RES_OFFER = 2'd1;
    localparam logic [1:0] RES_DRAIN = 2'd2;

    localparam array_pkg::acc_t RES_MAX =
        (array_pkg::acc_t'(1) <<< (array_pkg::RESULT_WIDTH - 1)) - 1;
    localparam array_pkg::acc_t RES_MIN =
        -(array_pkg::acc_t'(1) <<< (array_pkg::RESULT_WIDTH - 1));

    logic [dram_pkg::ROW_COUNT_WIDTH-1:0] take_cnt_q;
    logic [dram_pkg::SHIFT_WIDTH-1:0]     shift_q;
    logic                                 last_row;
    logic                                 closing_q;
    logic                                 s1_valid_q;
    logic                                 s1_last_q;
    logic                                 s2_last_q;
    logic                                 s3_last_q;
    logic [1:0]                           res_state_q;
    array_pkg::prod_t                     prod_q [ROW_LANES];
    array_pkg::acc_t                      row_sum;
    array_pkg::acc_t                      acc_q;
    array_pkg::acc_t                      shifted_q;
    array_pkg::result_t                   saturated;

    // closing_q blocks the next tile until its result is handed off
    assign row_take_o = feat_valid_i && wgt_valid_i && !closing_q;
    assign last_row   = (take_cnt_q == row_count_i - 1'b1);
    assign res_req_o  = (res_state_q == RES_OFFER);

    always_comb begin
        row_sum = '0;
        for (int i = 0; i < ROW_LANES; i++) begin
            row_sum = row_sum + array_pkg::acc_t'(prod_q[i]);
        end
    end

    // clamp to the 16-bit result range
    always_comb begin
        if (shifted_q > RES_MAX) begin
            saturated = array_pkg::result_t'(RES_MAX);
        end else if (shifted_q < RES_MIN) begin
            saturated = array_pkg::result_t'(RES_MIN);
        end else begin
            saturated = array_pkg::result_t'(shifted_q);
        end
    end

    //////////////////////////////////////////////////
    // pipeline control and tile accumulator
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rd_weight_rst) begin
            take_cnt_q  <= '0;
            closing_q   <= 1'b0;
            s1_valid_q  <= 1'b0;
            s1_last_q   <= 1'b0;
            s2_last_q   <= 1'b0;
            s3_last_q   <= 1'b0;
            acc_q       <= '0;
            res_state_q <= RES_IDLE;
        end else begin
            s1_valid_q <= row_take_o;
            s1_last_q  <= row_take_o && last_row;
            s2_last_q  <= s1_last_q;
            s3_last_q  <= s2_last_q;
            if (row_take_o && last_row) begin
                take_cnt_q <= '0;
                closing_q  <= 1'b1;
            end else if (row_take_o) begin
                take_cnt_q <= take_cnt_q + 1'b1;
            end
            if (s1_valid_q) begin
                acc_q <= acc_q + row_sum;
            end
            case (res_state_q)
                RES_IDLE: begin
                    if (s3_last_q) begin
                        res_state_q <= RES_OFFER;
                    end
                end
                RES_OFFER: begin
                    if (res_ack_i) begin
                        res_state_q <= RES_DRAIN;
                        acc_q       <= '0;
                    end
                end
                default: begin
                    if (!res_ack_i) begin
                        res_state_q <= RES_IDLE;
                        closing_q   <= 1'b0;
                    end
                end
            endcase
        end
    end

    // products, tile shift and result word
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ROW_LANES; i++) begin
            prod_q[i] <= feat_row_i[i] * wgt_row_i[i];
        end
        if (row_take_o && last_row) begin
            shift_q <= frac_shift_i;
        end
        if (s2_last_q) begin
            shifted_q <= acc_q >>> shift_q;
        end
        if (s3_last_q) begin
            res_data_o <= saturated;
        end
    end

endmodule

// ==== design/weight_row_packer.sv ====
`timescale 1ns/1ps

module weight_row_packer #(
    parameter  int ROW_BEATS = 4,
    localparam int ROW_LANES = ROW_BEATS * dram_pkg::LANES_PER_BEAT,
    localparam int CNT_W     = $clog2(ROW_BEATS)
) (
    input  logic             clk_i,
    input  logic             rd_weight_rst,
    input  logic             req_i,
    input  dram_pkg::beat_u  data_i,
    output logic             ack_o,
    input  logic             row_take_i,
    output array_pkg::lane_t row_o [ROW_LANES],
    output logic             row_valid_o
);

    // lanes before the last beat of a row
    localparam int STAGE_LANES = ROW_LANES - dram_pkg::LANES_PER_BEAT;

    dram_pkg::beat_u  beat;
    logic             beat_valid;
    logic [CNT_W-1:0] beat_cnt_q;
    logic             row_full;
    array_pkg::lane_t stage_q [STAGE_LANES];

    beat_sink wgt_sink_inst (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .req_i        (req_i),
        .data_i       (data_i),
        .space_i      (!row_valid_o),
        .ack_o        (ack_o),
        .beat_o       (beat),
        .beat_valid_o (beat_valid)
    );

    assign row_full = beat_valid && (beat_cnt_q == CNT_W'(ROW_BEATS - 1));

    // staging row, filled beat by beat
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < ROW_BEATS - 1; b++) begin
            for (int l = 0; l < dram_pkg::LANES_PER_BEAT; l++) begin
                if (beat_valid && beat_cnt_q == CNT_W'(b)) begin
                    stage_q[b*dram_pkg::LANES_PER_BEAT + l] <=
                        array_pkg::lane_t'(beat.lanes[l]);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // held weight row
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rd_weight_rst) begin
            beat_cnt_q  <= '0;
            row_valid_o <= 1'b0;
            for (int i = 0; i < ROW_LANES; i++) begin
                row_o[i] <= '0;
            end
        end else begin
            if (row_take_i) begin
                row_valid_o <= 1'b0;
            end
            if (beat_valid) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            if (row_full) begin
                beat_cnt_q  <= '0;
                row_valid_o <= 1'b1;
                // last beat goes straight in, the rest from staging
                for (int i = 0; i < STAGE_LANES; i++) begin
                    row_o[i] <= stage_q[i];
                end
                for (int l = 0; l < dram_pkg::LANES_PER_BEAT; l++) begin
                    row_o[STAGE_LANES + l] <= array_pkg::lane_t'(beat.lanes[l]);
                end
            end
        end
    end

endmodule

// ==== design/feature_row_packer.sv ====
`timescale 1ns/1ps

module feature_row_packer #(
    parameter  int ROW_BEATS = 4,
    localparam int ROW_LANES = ROW_BEATS * dram_pkg::LANES_PER_BEAT,
    localparam int CNT_W     = $clog2(ROW_BEATS)
) (
    input  logic                                 clk_i,
    input  logic                                 rd_weight_rst,
    input  logic                                 req_i,
    input  dram_pkg::beat_u                      data_i,
    output logic                                 ack_o,
    input  logic                                 row_take_i,
    output array_pkg::lane_t                     row_o [ROW_LANES],
    output logic                                 row_valid_o,
    output logic [dram_pkg::ROW_COUNT_WIDTH-1:0] row_count_o,
    output logic [dram_pkg::SHIFT_WIDTH-1:0]     frac_shift_o
);

    dram_pkg::beat_u                      beat;
    logic                                 beat_valid;
    logic                                 hdr_mode_q;
    logic [CNT_W-1:0]                     beat_cnt_q;
    logic [dram_pkg::ROW_COUNT_WIDTH-1:0] rows_left_q;

    beat_sink feat_sink_inst (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .req_i        (req_i),
        .data_i       (data_i),
        .space_i      (!row_valid_o),
        .ack_o        (ack_o),
        .beat_o       (beat),
        .beat_valid_o (beat_valid)
    );

    //////////////////////////////////////////////////
    // header / data sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rd_weight_rst) begin
            hdr_mode_q  <= 1'b1;
            beat_cnt_q  <= '0;
            rows_left_q <= '0;
            row_valid_o <= 1'b0;
        end else begin
            if (row_take_i) begin
                row_valid_o <= 1'b0;
                rows_left_q <= rows_left_q - 1'b1;
                // last row of the tile gone, next beat is a header
                if (rows_left_q == 1) begin
                    hdr_mode_q <= 1'b1;
                end
            end
            if (beat_valid && hdr_mode_q) begin
                hdr_mode_q  <= 1'b0;
                rows_left_q <= beat.hdr.row_count;
            end else if (beat_valid) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (beat_cnt_q == CNT_W'(ROW_BEATS - 1)) begin
                    beat_cnt_q  <= '0;
                    row_valid_o <= 1'b1;
                end
            end
        end
    end

    // tile fields and row lanes
    always_ff @(posedge clk_i) begin
        if (beat_valid && hdr_mode_q) begin
            row_count_o  <= beat.hdr.row_count;
            frac_shift_o <= beat.hdr.frac_shift;
        end else if (beat_valid) begin
            for (int b = 0; b < ROW_BEATS; b++) begin
                if (beat_cnt_q == CNT_W'(b)) begin
                    for (int l = 0; l < dram_pkg::LANES_PER_BEAT; l++) begin
                        row_o[b*dram_pkg::LANES_PER_BEAT + l] <=
                            array_pkg::lane_t'(beat.lanes[l]);
                    end
                end
            end
        end
    end

endmodule

// ==== design/beat_sink.sv ====
`timescale 1ns/1ps

module beat_sink (
    input  logic            clk_i,
    input  logic            rd_weight_rst,
    input  logic            req_i,
    input  dram_pkg::beat_u data_i,
    input  logic            space_i,
    output logic            ack_o,
    output dram_pkg::beat_u beat_o,
    output logic            beat_valid_o
);

    // four-phase receiver states
    localparam logic SINK_IDLE = 1'b0;
    localparam logic SINK_HELD = 1'b1;

    logic state_q;
    logic accept;

    // only take a beat when the packer has room for it
    assign accept = (state_q == SINK_IDLE) && req_i && space_i;
    assign ack_o  = (state_q == SINK_HELD);

    always_ff @(posedge clk_i) begin
        if (rd_weight_rst) begin
            state_q      <= SINK_IDLE;
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= accept;
            if (state_q == SINK_IDLE) begin
                if (accept) begin
                    state_q <= SINK_HELD;
                end
            end else if (!req_i) begin
                // sender has let go, return to idle
                state_q <= SINK_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            beat_o <= data_i;
        end
    end

endmodule

// ==== design/array_pkg.sv ====
package array_pkg;

    //////////////////////////////////////////////////
    // compute core number formats
    //////////////////////////////////////////////////

    // integer part of a lane
    localparam int LANE_WIDTH = 8;

    typedef logic signed [LANE_WIDTH-1:0] lane_t;

    // full precision lane product
    typedef logic signed [2*LANE_WIDTH-1:0] prod_t;

    // tile accumulator, wide enough for 255 rows of 16 lanes
    localparam int ACC_WIDTH = 32;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // scaled and saturated tile result
    localparam int RESULT_WIDTH = 16;

    typedef logic signed [RESULT_WIDTH-1:0] result_t;

endpackage

// ==== design/dram_pkg.sv ====
package dram_pkg;

    //////////////////////////////////////////////////
    // beat geometry
    //////////////////////////////////////////////////

    localparam int BEAT_WIDTH     = 32;
    localparam int LANES_PER_BEAT = 4;
    localparam int BEAT_LANE_BITS = BEAT_WIDTH / LANES_PER_BEAT;

    // tile header fields
    localparam int ROW_COUNT_WIDTH = 8;
    localparam int SHIFT_WIDTH     = 4;

    // named signed type so a lane select stays signed
    typedef logic signed [BEAT_LANE_BITS-1:0] beat_lane_t;

    // same word seen as a tile header or as four data lanes
    // lane 0 sits in the low byte
    typedef union packed {
        beat_lane_t [LANES_PER_BEAT-1:0] lanes;
        struct packed {
            logic [BEAT_WIDTH-ROW_COUNT_WIDTH-SHIFT_WIDTH-1:0] reserved;
            logic [SHIFT_WIDTH-1:0]                            frac_shift;
            logic [ROW_COUNT_WIDTH-1:0]                        row_count;
        } hdr;
    } beat_u;

endpackage
